//--- source/dds_types_pkg.sv
// ----------------------------------------
// numeric widths and vector types shared by the synthesizer.
// reference them as dds_types_pkg::name
// ----------------------------------------
`default_nettype none

package dds_types_pkg;

  // phase accumulator width, full circle is 2**PHASE_BITS
  localparam int PHASE_BITS = 20;

  // low phase bits dropped before the table lookup
  localparam int QUANT_BITS = 8;

  // table index width and depth
  localparam int LUT_ADDR_BITS = PHASE_BITS - QUANT_BITS;
  localparam int LUT_DEPTH = 1 << LUT_ADDR_BITS;

  // signed output sample width
  localparam int OUTPUT_WIDTH = 16;

  // samples produced per beat
  localparam int PARALLEL_SAMPLES = 4;

  // dither generator width and feedback taps 16, 15, 13, 4
  localparam int LFSR_WIDTH = 16;
  localparam logic [LFSR_WIDTH-1:0] LFSR_TAP_MASK = 16'hD008;

  // register stages from phase accumulator to sample output
  localparam int DDS_LATENCY = 5;

  // one bit of headroom for the two-tone sum
  localparam int SUM_WIDTH = OUTPUT_WIDTH + 1;

  // constant for the cosine table
  localparam real PI = 3.14159265358979323846;

  // phase or phase increment, wraps modulo 2**PHASE_BITS
  typedef logic [PHASE_BITS-1:0] phase_t;

  // quantized phase, used as the table index
  typedef logic [LUT_ADDR_BITS-1:0] lut_addr_t;

  // one cosine sample
  typedef logic signed [OUTPUT_WIDTH-1:0] sample_t;

  // lane 0 sits in the low bits
  typedef sample_t [PARALLEL_SAMPLES-1:0] sample_vec_t;

  // lane sum before halving
  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  // one dither word from the LFSR
  typedef logic [LFSR_WIDTH-1:0] lfsr_word_t;

endpackage

`default_nettype wire

//--- source/dds_stream_pkg.sv
// ----------------------------------------
// stream beat structs carried between channel,
// combiner and top level
// ----------------------------------------
`default_nettype none

package dds_stream_pkg;

  // phase increment beat
  // no ready travels back, the channel takes every valid beat
  typedef struct packed {
    // high for one cycle to load a new increment
    logic                  valid;
    // phase step per output sample
    dds_types_pkg::phase_t inc;
  } phase_inc_beat_t;

  // sample vector beat, uses the valid/ready handshake
  // valid stays high with samples held until the beat transfers
  typedef struct packed {
    // beat holds data
    logic                       valid;
    // PARALLEL_SAMPLES lanes, lane 0 in the low bits
    dds_types_pkg::sample_vec_t samples;
  } sample_beat_t;

endpackage

`default_nettype wire

//--- source/lfsr16_parallel.sv
// ----------------------------------------
// 16-bit fibonacci LFSR, several steps per enable.
// each step comes out as one lane's dither word
// ----------------------------------------
`default_nettype none

module lfsr16_parallel #(
  parameter int PARALLEL_SAMPLES = dds_types_pkg::PARALLEL_SAMPLES,
  parameter dds_types_pkg::lfsr_word_t SEED = 16'h0001
) (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic                                            enable,
  output dds_types_pkg::lfsr_word_t [PARALLEL_SAMPLES-1:0] data_out
);

  // one shift, new bit enters at the bottom
  function automatic dds_types_pkg::lfsr_word_t lfsr_step(
    input dds_types_pkg::lfsr_word_t cur
  );
    logic feedback;
    feedback = ^(cur & dds_types_pkg::LFSR_TAP_MASK);
    return {cur[dds_types_pkg::LFSR_WIDTH-2:0], feedback};
  endfunction

  // current LFSR state, last lane of the previous enable
  dds_types_pkg::lfsr_word_t state;

  // state after 0..PARALLEL_SAMPLES steps
  dds_types_pkg::lfsr_word_t [PARALLEL_SAMPLES:0] step_chain;

  // unroll the steps for one enable
  always_comb begin
    step_chain[0] = state;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      step_chain[i+1] = lfsr_step(step_chain[i]);
    end
  end

  // state restarts at the seed
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SEED;
    end else if (enable) begin
      state <= step_chain[PARALLEL_SAMPLES];
    end
  end

  // dither words, lane i gets step i+1
  always_ff @(posedge clk) begin
    if (enable) begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        data_out[i] <= step_chain[i+1];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/dds.sv
// ----------------------------------------
// one DDS channel, phase increment in and four
// dithered cosine samples per beat out
// ----------------------------------------
`default_nettype none

module dds #(
  parameter dds_types_pkg::lfsr_word_t DITHER_SEED = 16'h0001
) (
  input  logic                            clk,
  input  logic                            reset,
  input  dds_stream_pkg::phase_inc_beat_t phase_inc_in,
  output dds_stream_pkg::sample_beat_t    cos_out,
  input  logic                            cos_ready
);

  // table entry j is floor(cos(2*pi*j/depth) * (2**(w-1) - 0.5) - 0.5)
  function automatic dds_types_pkg::sample_t cos_entry(input int j);
    real angle;
    real scaled;
    angle = 2.0 * dds_types_pkg::PI * real'(j) / real'(dds_types_pkg::LUT_DEPTH);
    scaled = $cos(angle) * (2.0 ** (dds_types_pkg::OUTPUT_WIDTH - 1) - 0.5) - 0.5;
    return dds_types_pkg::sample_t'(int'($floor(scaled)));
  endfunction

  // full-circle cosine ROM
  // indexed over 0..2pi so phase wrap and dither need no folding
  dds_types_pkg::sample_t cos_lut [dds_types_pkg::LUT_DEPTH];

  initial begin
    for (int j = 0; j < dds_types_pkg::LUT_DEPTH; j++) begin
      cos_lut[j] = cos_entry(j);
    end
  end

  // lane_inc[i] = (i+1)*d, last entry steps the cycle phase
  dds_types_pkg::phase_t [dds_types_pkg::PARALLEL_SAMPLES-1:0] lane_inc;
  // only accumulated quantity, phase of lane 0
  dds_types_pkg::phase_t cycle_phase;
  // stage 1, per-lane phase
  dds_types_pkg::phase_t [dds_types_pkg::PARALLEL_SAMPLES-1:0] sample_phase;
  // stage 2, phase plus dither
  dds_types_pkg::phase_t [dds_types_pkg::PARALLEL_SAMPLES-1:0] phase_dithered;
  // stage 3, table address
  dds_types_pkg::lut_addr_t [dds_types_pkg::PARALLEL_SAMPLES-1:0] phase_quant;
  // stage 4, table read
  dds_types_pkg::sample_vec_t lut_q;
  // stage 5, output samples
  dds_types_pkg::sample_vec_t cos_q;
  // pipeline fill marker, top bit is output valid
  logic [dds_types_pkg::DDS_LATENCY-1:0] valid_sr;
  // dither words, one per lane
  dds_types_pkg::lfsr_word_t [dds_types_pkg::PARALLEL_SAMPLES-1:0] dither_word;
  // whole pipeline moves together
  logic advance;

  // move when the output is empty or being taken
  assign advance = cos_ready || !valid_sr[dds_types_pkg::DDS_LATENCY-1];

  assign cos_out = '{valid: valid_sr[dds_types_pkg::DDS_LATENCY-1], samples: cos_q};

  // dither source, holds with the pipeline under back-pressure
  lfsr16_parallel #(
    .PARALLEL_SAMPLES(dds_types_pkg::PARALLEL_SAMPLES),
    .SEED(DITHER_SEED)
  ) u_lfsr (
    .clk(clk),
    .reset(reset),
    .enable(advance),
    .data_out(dither_word)
  );

  // increments load on any valid beat, independent of the stall
  always_ff @(posedge clk) begin
    if (reset) begin
      lane_inc <= '0;
    end else if (phase_inc_in.valid) begin
      for (int i = 0; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
        lane_inc[i] <= dds_types_pkg::phase_t'(phase_inc_in.inc * (i + 1));
      end
    end
  end

  // phase accumulation and lane phases
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_phase <= '0;
      sample_phase <= '0;
      valid_sr <= '0;
      cos_q <= '0;
    end else if (advance) begin
      // jump four samples ahead, wraps naturally
      cycle_phase <= cycle_phase + lane_inc[dds_types_pkg::PARALLEL_SAMPLES-1];
      // lane phases come from the phase before the step
      sample_phase[0] <= cycle_phase;
      for (int i = 1; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
        sample_phase[i] <= cycle_phase + lane_inc[i-1];
      end
      cos_q <= lut_q;
      valid_sr <= {valid_sr[dds_types_pkg::DDS_LATENCY-2:0], 1'b1};
    end
  end

  // dither, quantize, look up
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
        // low dither bits only, a clean phase never carries
        phase_dithered[i] <= sample_phase[i]
          + dds_types_pkg::phase_t'(dither_word[i][dds_types_pkg::QUANT_BITS-1:0]);
        // drop the dithered fraction
        phase_quant[i] <=
          phase_dithered[i][dds_types_pkg::PHASE_BITS-1:dds_types_pkg::QUANT_BITS];
        lut_q[i] <= cos_lut[phase_quant[i]];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/tone_combiner.sv
// ----------------------------------------
// joins two sample streams and outputs the
// lane-wise average floor((a+b)/2)
// ----------------------------------------
`default_nettype none

module tone_combiner (
  input  logic                         clk,
  input  logic                         reset,
  input  dds_stream_pkg::sample_beat_t beat_a,
  input  dds_stream_pkg::sample_beat_t beat_b,
  output logic                         ready_a,
  output logic                         ready_b,
  output dds_stream_pkg::sample_beat_t out_beat,
  input  logic                         out_ready
);

  // both inputs taken in the same cycle
  logic take;
  // averaged lanes, registered on take
  dds_types_pkg::sample_vec_t avg;
  // output register
  logic out_valid;
  dds_types_pkg::sample_vec_t out_samples;

  // join needs both beats and room in the output register
  assign take = beat_a.valid && beat_b.valid && (!out_valid || out_ready);

  // same strobe to both sides keeps the channels in lock step
  assign ready_a = take;
  assign ready_b = take;

  // sum at one extra bit, then drop the lsb
  // taking the upper bits of a two's complement sum rounds toward minus infinity
  always_comb begin
    dds_types_pkg::sample_t lane_a;
    dds_types_pkg::sample_t lane_b;
    dds_types_pkg::sum_t lane_sum;
    for (int i = 0; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
      lane_a = beat_a.samples[i];
      lane_b = beat_b.samples[i];
      lane_sum = lane_a + lane_b;
      avg[i] = lane_sum[dds_types_pkg::SUM_WIDTH-1:1];
    end
  end

  // output beat holds until drained
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_samples <= '0;
    end else if (take) begin
      out_valid <= 1'b1;
      out_samples <= avg;
    end else if (out_ready) begin
      // drained with nothing new behind it
      out_valid <= 1'b0;
    end
  end

  assign out_beat = '{valid: out_valid, samples: out_samples};

endmodule

`default_nettype wire

//--- source/two_tone_synth.sv
// ----------------------------------------
// two-tone synthesizer top, two DDS channels
// averaged into one sample stream
// ----------------------------------------
`default_nettype none

module two_tone_synth (
  input  logic                            clk,
  input  logic                            reset,
  input  dds_stream_pkg::phase_inc_beat_t tone_a_inc,
  input  dds_stream_pkg::phase_inc_beat_t tone_b_inc,
  output dds_stream_pkg::sample_beat_t    out_beat,
  input  logic                            out_ready
);

  // channel beats into the combiner
  dds_stream_pkg::sample_beat_t beat_a;
  dds_stream_pkg::sample_beat_t beat_b;
  // join strobes back to the channels
  logic ready_a;
  logic ready_b;

  // tone A
  // distinct seeds keep the two dither sequences uncorrelated
  dds #(
    .DITHER_SEED(16'hACE1)
  ) u_tone_a (
    .clk(clk),
    .reset(reset),
    .phase_inc_in(tone_a_inc),
    .cos_out(beat_a),
    .cos_ready(ready_a)
  );

  // tone B
  dds #(
    .DITHER_SEED(16'h5B3D)
  ) u_tone_b (
    .clk(clk),
    .reset(reset),
    .phase_inc_in(tone_b_inc),
    .cos_out(beat_b),
    .cos_ready(ready_b)
  );

  // lane-wise average, one cycle after the join
  tone_combiner u_combiner (
    .clk(clk),
    .reset(reset),
    .beat_a(beat_a),
    .beat_b(beat_b),
    .ready_a(ready_a),
    .ready_b(ready_b),
    .out_beat(out_beat),
    .out_ready(out_ready)
  );

endmodule

`default_nettype wire

//--- tb/two_tone_synth_tb.sv
// ----------------------------------------
// directed testbench for the two-tone synthesizer.
// checks averaged cosine beats against a reference model
// ----------------------------------------
`default_nettype none

module two_tone_synth_tb;

  // 8 time unit clock period
  localparam int CLK_HALF = 4;
  localparam int RESET_CYCLES = 8;
  // at most about 300 cycles per test, with ample margin
  localparam int TIMEOUT_CYCLES = 3000;
  // out_beat valid after reset release with out_ready high
  localparam int FIRST_BEAT_CYCLES = 6;
  // combiner register plus five channel stages hold phase-0 beats
  localparam int STALE_BEATS = 6;
  localparam int FULL_SCALE = 32767;
  localparam logic [15:0] RAND_SEED = 16'd64;
  localparam longint PHASE_MOD = longint'(1) << dds_types_pkg::PHASE_BITS;
  localparam int TABLE_SIZE = 1 << (dds_types_pkg::PHASE_BITS - dds_types_pkg::QUANT_BITS);
  localparam real PI_VAL = 3.14159265358979323846;

  logic clk;
  logic reset;
  dds_stream_pkg::phase_inc_beat_t tone_a_inc;
  dds_stream_pkg::phase_inc_beat_t tone_b_inc;
  dds_stream_pkg::sample_beat_t out_beat;
  logic out_ready;

  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int cycle_count = 0;
  // out_ready randomizer state
  logic [15:0] rand_state;

  two_tone_synth u_dut (
    .clk(clk),
    .reset(reset),
    .tone_a_inc(tone_a_inc),
    .tone_b_inc(tone_b_inc),
    .out_beat(out_beat),
    .out_ready(out_ready)
  );

  always #CLK_HALF clk = ~clk;

  // run limit, a stuck handshake ends here
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // table entry j = floor(cos(2*pi*j/4096) * 32767.5 - 0.5)
  function automatic int cos_model(input int j);
    real angle;
    angle = 2.0 * PI_VAL * real'(j) / real'(TABLE_SIZE);
    return int'($floor($cos(angle) * 32767.5 - 0.5));
  endfunction

  // sample number n sits at phase n*d, modulo the full circle
  function automatic int table_index(input int inc, input int n);
    longint phase;
    phase = (longint'(inc) * longint'(n)) % PHASE_MOD;
    return int'(phase >> dds_types_pkg::QUANT_BITS);
  endfunction

  // rounds toward minus infinity
  function automatic int floor_half(input int s);
    if (s < 0 && (s % 2) != 0) begin
      return (s - 1) / 2;
    end else begin
      return s / 2;
    end
  endfunction

  // expected output lane of beat k
  function automatic int expected_lane(input int inc_a, input int inc_b,
                                       input int beat, input int lane);
    int n;
    n = dds_types_pkg::PARALLEL_SAMPLES * beat + lane;
    return floor_half(cos_model(table_index(inc_a, n)) + cos_model(table_index(inc_b, n)));
  endfunction

  function automatic int lane_of(input dds_types_pkg::sample_vec_t vec, input int lane);
    return int'($signed(vec[lane]));
  endfunction

  // phase-0 beat from both channels
  function automatic bit all_full_scale(input dds_types_pkg::sample_vec_t vec);
    bit all_max;
    all_max = 1'b1;
    for (int i = 0; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
      if (lane_of(vec, i) != FULL_SCALE) begin
        all_max = 1'b0;
      end
    end
    return all_max;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("FAILED %s: expected %0d, actual %0d", what, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_count++;
    $display("test %s finished with %0d errors", name, error_count - err_before);
  endtask

  // reset for RESET_CYCLES edges, increments idle
  task automatic apply_reset(input logic ready_level);
    @(posedge clk);
    reset <= 1'b1;
    out_ready <= ready_level;
    tone_a_inc <= '0;
    tone_b_inc <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one-cycle valid pulse on both increment inputs
  task automatic load_increments(input int inc_a, input int inc_b);
    @(posedge clk);
    tone_a_inc <= '{valid: 1'b1, inc: dds_types_pkg::phase_t'(inc_a)};
    tone_b_inc <= '{valid: 1'b1, inc: dds_types_pkg::phase_t'(inc_b)};
    @(posedge clk);
    tone_a_inc <= '0;
    tone_b_inc <= '0;
  endtask

  task automatic test_reset_state();
    int err_before;
    int cycles;
    err_before = error_count;
    @(posedge clk);
    reset <= 1'b1;
    out_ready <= 1'b1;
    tone_a_inc <= '0;
    tone_b_inc <= '0;
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      if (c == RESET_CYCLES - 1) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      check_value("reset_state valid during reset", 0, int'(out_beat.valid));
    end
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      if (cycles == 1) begin
        check_value("reset_state valid after release", 0, int'(out_beat.valid));
      end
    end while (!out_beat.valid && cycles < 4 * FIRST_BEAT_CYCLES);
    check_value("reset_state cycles to first beat", FIRST_BEAT_CYCLES, cycles);
    // full pipeline, one beat per cycle
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      check_value("reset_state steady valid", 1, int'(out_beat.valid));
    end
    report_test("reset_state", err_before);
  endtask

  // reset stalled, load increments, then stream and compare n_beats
  task automatic run_stream(input string name, input int inc_a, input int inc_b,
                            input int n_beats, input bit random_ready);
    int err_before;
    int k;
    int skipped;
    bit waiting;
    logic ready_bit;
    dds_types_pkg::sample_vec_t held;
    err_before = error_count;
    apply_reset(1'b0);
    // pipelines fill with phase-0 beats and stall
    do begin
      @(negedge clk);
    end while (!out_beat.valid);
    load_increments(inc_a, inc_b);
    out_ready <= 1'b1;
    k = 0;
    skipped = 0;
    waiting = 1'b0;
    held = '0;
    while (k < n_beats) begin
      @(negedge clk);
      // a waiting beat keeps valid and data
      if (waiting) begin
        check_value($sformatf("%s held valid", name), 1, int'(out_beat.valid));
        for (int i = 0; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
          check_value($sformatf("%s held lane %0d", name, i),
                      lane_of(held, i), lane_of(out_beat.samples, i));
        end
      end
      if (out_beat.valid && out_ready) begin
        waiting = 1'b0;
        if (k == 0 && all_full_scale(out_beat.samples)) begin
          skipped++;
          if (skipped > STALE_BEATS) begin
            error_count++;
            $display("%s: more stale beats than the pipeline can hold", name);
            break;
          end
        end else begin
          // every stage drained before the new tone appears
          if (k == 0) begin
            check_value($sformatf("%s stale beats", name), STALE_BEATS, skipped);
          end
          for (int i = 0; i < dds_types_pkg::PARALLEL_SAMPLES; i++) begin
            check_value($sformatf("%s beat %0d lane %0d", name, k, i),
                        expected_lane(inc_a, inc_b, k, i), lane_of(out_beat.samples, i));
          end
          k++;
        end
      end else begin
        waiting = out_beat.valid;
        held = out_beat.samples;
      end
      @(posedge clk);
      if (random_ready) begin
        rand_state = lfsr_advance(rand_state);
        ready_bit = rand_state[0];
      end else begin
        ready_bit = 1'b1;
      end
      out_ready <= ready_bit;
    end
    report_test(name, err_before);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    out_ready = 1'b0;
    tone_a_inc = '0;
    tone_b_inc = '0;
    rand_state = RAND_SEED;

    test_reset_state();
    // A at a sixteenth of the circle, B silent at phase 0
    run_stream("single_tone", (1 << dds_types_pkg::PHASE_BITS) / 16, 0, 16, 1'b0);
    run_stream("two_tones", 32'h06A00, 32'h23500, 32, 1'b0);
    run_stream("back_pressure", 32'h12300, 32'h04700, 40, 1'b1);
    // near full scale, phases step backwards through zero
    run_stream("phase_wrap", (1 << dds_types_pkg::PHASE_BITS) - 256,
               (1 << dds_types_pkg::PHASE_BITS) - 4096, 64, 1'b0);

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
source/dds_types_pkg.sv
source/dds_stream_pkg.sv
source/lfsr16_parallel.sv
source/dds.sv
source/tone_combiner.sv
source/two_tone_synth.sv
tb/two_tone_synth_tb.sv

//--- Makefile
# Verilator build and run for the two-tone synthesizer testbench
# override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= two_tone_synth_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= sim passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass or fail comes from the log, not the exit code of the binary
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "run result: ok"; \
	else \
		echo "run result: pass line missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
